// ==== list.f ====
design/bank_cmd_pkg.sv
design/dram_timing_pkg.sv
design/bank_req_queue.sv
design/bank_timers.sv
design/bank_fsm.sv
design/bank_cmd_out.sv
design/bank_machine.sv
tests/bank_machine_tb.sv

// ==== Bender.yml ====
package:
  name: bank_machine

sources:
  - design/bank_cmd_pkg.sv
  - design/dram_timing_pkg.sv
  - design/bank_req_queue.sv
  - design/bank_timers.sv
  - design/bank_fsm.sv
  - design/bank_cmd_out.sv
  - design/bank_machine.sv
  - target: test
    files:
      - tests/bank_machine_tb.sv

// ==== tests/bank_machine_tb.sv ====
module bank_machine_tb
   import bank_cmd_pkg::*;
   import dram_timing_pkg::*;
();

   localparam int N_REQ = 18;
   localparam int N_HOLD = 12;   // cycles of back-pressure

   // requests 0..3 stay on one row, 4..7 switch rows and 8..17 run under back-pressure
   int tbl_row   [N_REQ] = '{5, 5, 5, 5, 9, 9, 5, 9, 9, 9, 3, 3, 3, 7, 7, 7, 3, 3};
   int tbl_col   [N_REQ] = '{10, 11, 12, 13, 20, 21, 30, 40, 50, 51,
                             60, 61, 62, 70, 71, 72, 80, 81};
   bit tbl_write [N_REQ] = '{0, 1, 0, 1, 1, 0, 0, 1, 0, 1, 0, 1, 0, 1, 0, 0, 1, 0};
   int tbl_id    [N_REQ] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10,
                             11, 12, 13, 14, 15, 16, 17, 18};

   logic             clk;
   logic             rst_n;
   logic             req_valid_i;
   logic [ROW_W-1:0] req_row_i;
   logic [COL_W-1:0] req_col_i;
   logic             req_write_i;
   logic [ID_W-1:0]  req_id_i;
   logic             req_ready_o;
   logic             cmd_valid_o;
   bank_op_e         cmd_op_o;
   logic [ROW_W-1:0] cmd_addr_o;
   logic [ID_W-1:0]  cmd_id_o;
   logic             cmd_ready_i;
   logic             idle_o;

   integer seed = 32'h8ae4;
   bit     hold_ready;       // forces cmd_ready_i low
   int     cyc;
   int     err_cnt;
   int     test_err_start;
   int     tests_run;
   int     tests_failed;
   int     n_accepted;
   int     n_fired;
   string  cur_test;
   int     exp_op   [$];     // expected command stream
   int     exp_addr [$];
   int     exp_id   [$];
   bit     model_vld;        // open row of the reference model
   int     model_row;
   int     last_act = -100;
   int     last_pre = -100;
   int     last_rd  = -100;
   int     last_wr  = -100;

   bank_machine u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid_i (req_valid_i),
      .req_row_i   (req_row_i),
      .req_col_i   (req_col_i),
      .req_write_i (req_write_i),
      .req_id_i    (req_id_i),
      .req_ready_o (req_ready_o),
      .cmd_valid_o (cmd_valid_o),
      .cmd_op_o    (cmd_op_o),
      .cmd_addr_o  (cmd_addr_o),
      .cmd_id_o    (cmd_id_o),
      .cmd_ready_i (cmd_ready_i),
      .idle_o      (idle_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // mux is ready about three cycles in four
   always @(posedge clk)
   begin
      #1;
      if (hold_ready)
         cmd_ready_i = 1'b0;
      else
         cmd_ready_i = ($random(seed) % 4) != 0;
   end

   task automatic check(input string what, input logic [31:0] expv, input logic [31:0] actv);
      if (expv !== actv)
      begin
         $display("CHECK FAILED %s %s: expected %0d, actual %0d", cur_test, what, expv, actv);
         err_cnt++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_cnt;
      tests_run++;
   endtask

   task automatic finish_test();
      if (err_cnt != test_err_start)
         tests_failed++;
      $display("test %s finished, %0d errors", cur_test, err_cnt - test_err_start);
   endtask

   // open-page model closes the old row on a row change
   task automatic expect_cmds(input int i);
      if (model_vld && model_row != tbl_row[i])
      begin
         exp_op.push_back(OP_PRE);
         exp_addr.push_back(0);
         exp_id.push_back(0);
      end
      if (!model_vld || model_row != tbl_row[i])
      begin
         exp_op.push_back(OP_ACT);
         exp_addr.push_back(tbl_row[i]);
         exp_id.push_back(0);
      end
      exp_op.push_back(tbl_write[i] ? OP_WR : OP_RD);
      exp_addr.push_back(tbl_col[i]);
      exp_id.push_back(tbl_id[i]);
      model_row = tbl_row[i];
      model_vld = 1'b1;
   endtask

   task automatic send_req(input int i);
      int t;
      req_valid_i = 1'b1;
      req_row_i   = ROW_W'(tbl_row[i]);
      req_col_i   = COL_W'(tbl_col[i]);
      req_write_i = tbl_write[i];
      req_id_i    = ID_W'(tbl_id[i]);
      t = 0;
      do
      begin
         @(posedge clk);
         t++;
      end
      while (!req_ready_o && t < 200);
      if (!req_ready_o)
         abort_run($sformatf("request %0d was never accepted by the bank", i));
      else
      begin
         expect_cmds(i);
         n_accepted++;
         #1 req_valid_i = 1'b0;
      end
   endtask

   task automatic wait_idle();
      int t;
      t = 0;
      do
      begin
         @(posedge clk);
         t++;
      end
      while (!idle_o && t < 200);
      if (!idle_o)
         abort_run("bank did not return to idle after the last request");
      else
      begin
         check("commands left", 0, exp_op.size());
         #1;
      end
   endtask

   // compare each handshake with the model and the spacing rules
   task automatic log_command();
      if (exp_op.size() == 0)
      begin
         $display("%s command issued with no request waiting for it", cmd_op_o.name());
         err_cnt++;
         return;
      end
      check("opcode", exp_op.pop_front(), cmd_op_o);
      check("address", exp_addr.pop_front(), cmd_addr_o);
      check("id", exp_id.pop_front(), cmd_id_o);
      n_fired++;
      case (cmd_op_o)
         OP_ACT:
         begin
            check("tRP", 1, (cyc - last_pre) >= int'(T_RP));
            last_act = cyc;
         end
         OP_PRE:
         begin
            check("tRAS", 1, (cyc - last_act) >= int'(T_RAS));
            check("tWR2PRE", 1, (cyc - last_wr) >= int'(T_WR2PRE));
            check("tRD2PRE", 1, (cyc - last_rd) >= int'(T_RD2PRE));
            last_pre = cyc;
         end
         OP_RD:
         begin
            check("tRCD", 1, (cyc - last_act) >= int'(T_RCD));
            last_rd = cyc;
         end
         default:
         begin
            check("tRCD", 1, (cyc - last_act) >= int'(T_RCD));
            last_wr = cyc;
         end
      endcase
   endtask

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (rst_n && cmd_valid_o && cmd_ready_i)
         log_command();
   end

   task automatic hold_and_check();
      int t;
      t = 0;
      do
      begin
         @(posedge clk);
         t++;
      end
      while (!cmd_valid_o && t < 20);
      if (!cmd_valid_o)
         abort_run("no command appeared while the mux was stalled");
      else
      begin
         // the held command is the oldest one the model still expects
         repeat (N_HOLD)
         begin
            @(posedge clk);
            check("held valid", 1, cmd_valid_o);
            check("held opcode", exp_op[0], cmd_op_o);
            check("held address", exp_addr[0], cmd_addr_o);
            check("held id", exp_id[0], cmd_id_o);
         end
         // full queue plus the cas sitting in the output register
         check("accepted while stalled", QUEUE_DEPTH + 1, n_accepted - 8);
         check("req_ready_o when full", 0, req_ready_o);
         @(negedge clk) hold_ready = 1'b0;
      end
   endtask

   initial
   begin
      rst_n       = 1'b0;
      req_valid_i = 1'b0;
      req_row_i   = '0;
      req_col_i   = '0;
      req_write_i = 1'b0;
      req_id_i    = '0;
      cmd_ready_i = 1'b0;
      hold_ready  = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      start_test("reset_idle");
      repeat (10)
      begin
         @(posedge clk);
         check("cmd_valid_o", 0, cmd_valid_o);
         check("idle_o", 1, idle_o);
      end
      #1;
      finish_test();

      start_test("same_row");
      for (int i = 0; i < 4; i++)
         send_req(i);
      wait_idle();
      finish_test();

      start_test("row_miss");
      for (int i = 4; i < 8; i++)
         send_req(i);
      wait_idle();
      finish_test();

      start_test("backpressure");
      @(negedge clk) hold_ready = 1'b1;
      @(posedge clk);
      #1;
      fork
         for (int i = 8; i < N_REQ; i++)
            send_req(i);
         hold_and_check();
      join
      wait_idle();
      finish_test();

      $display("%0d tests, %0d failed, %0d check errors, %0d commands seen",
               tests_run, tests_failed, err_cnt, n_fired);
      if (err_cnt == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== design/bank_machine.sv ====
module bank_machine
   import bank_cmd_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req_valid_i,
   input  logic [ROW_W-1:0] req_row_i,
   input  logic [COL_W-1:0] req_col_i,
   input  logic             req_write_i,
   input  logic [ID_W-1:0]  req_id_i,
   output logic             req_ready_o,
   output logic             cmd_valid_o,
   output bank_op_e         cmd_op_o,
   output logic [ROW_W-1:0] cmd_addr_o,
   output logic [ID_W-1:0]  cmd_id_o,
   input  logic             cmd_ready_i,
   output logic             idle_o
);

   // queue head
   logic             q_valid;
   logic [ROW_W-1:0] q_row;
   logic [COL_W-1:0] q_col;
   logic             q_write;
   logic [ID_W-1:0]  q_id;
   logic             q_miss;
   logic             q_pop;

   logic             issue;
   bank_op_e         issue_op;
   logic [ROW_W-1:0] issue_addr;
   logic [ID_W-1:0]  issue_id;
   logic             out_free;
   logic             cmd_fire;
   bank_op_e         fired_op;
   logic             act_ok;
   logic             cas_ok;
   logic             pre_ok;

   bank_req_queue u_queue (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid_i  (req_valid_i),
      .req_row_i    (req_row_i),
      .req_col_i    (req_col_i),
      .req_write_i  (req_write_i),
      .req_id_i     (req_id_i),
      .pop_i        (q_pop),
      .req_ready_o  (req_ready_o),
      .head_valid_o (q_valid),
      .head_row_o   (q_row),
      .head_col_o   (q_col),
      .head_write_o (q_write),
      .head_id_o    (q_id),
      .head_miss_o  (q_miss)
   );

   bank_fsm u_fsm (
      .clk          (clk),
      .rst_n        (rst_n),
      .head_valid_i (q_valid),
      .head_row_i   (q_row),
      .head_col_i   (q_col),
      .head_write_i (q_write),
      .head_id_i    (q_id),
      .head_miss_i  (q_miss),
      .act_ok_i     (act_ok),
      .cas_ok_i     (cas_ok),
      .pre_ok_i     (pre_ok),
      .out_free_i   (out_free),
      .fire_i       (cmd_fire),
      .pop_o        (q_pop),
      .issue_o      (issue),
      .issue_op_o   (issue_op),
      .issue_addr_o (issue_addr),
      .issue_id_o   (issue_id),
      .idle_o       (idle_o)
   );

   bank_timers u_timers (
      .clk       (clk),
      .rst_n     (rst_n),
      .fire_i    (cmd_fire),
      .fire_op_i (fired_op),
      .act_ok_o  (act_ok),
      .cas_ok_o  (cas_ok),
      .pre_ok_o  (pre_ok)
   );

   bank_cmd_out u_cmd_out (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_i      (issue),
      .load_op_i   (issue_op),
      .load_addr_i (issue_addr),
      .load_id_i   (issue_id),
      .cmd_ready_i (cmd_ready_i),
      .free_o      (out_free),
      .cmd_valid_o (cmd_valid_o),
      .cmd_op_o    (cmd_op_o),
      .cmd_addr_o  (cmd_addr_o),
      .cmd_id_o    (cmd_id_o),
      .fire_o      (cmd_fire),
      .fire_op_o   (fired_op)
   );

endmodule

// ==== design/bank_cmd_out.sv ====
module bank_cmd_out
   import bank_cmd_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             load_i,
   input  bank_op_e         load_op_i,
   input  logic [ROW_W-1:0] load_addr_i,
   input  logic [ID_W-1:0]  load_id_i,
   input  logic             cmd_ready_i,
   output logic             free_o,
   output logic             cmd_valid_o,
   output bank_op_e         cmd_op_o,
   output logic [ROW_W-1:0] cmd_addr_o,
   output logic [ID_W-1:0]  cmd_id_o,
   output logic             fire_o,
   output bank_op_e         fire_op_o
);

   logic             valid_q;
   bank_op_e         op_q;
   logic [ROW_W-1:0] addr_q;
   logic [ID_W-1:0]  id_q;
   logic             take;

   assign fire_o    = valid_q & cmd_ready_i;
   assign fire_op_o = op_q;
   assign free_o    = ~valid_q | cmd_ready_i;   // slot empties in the handshake cycle
   assign take      = load_i & free_o;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      else if (take)
         valid_q <= 1'b1;
      else if (fire_o)
         valid_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         op_q   <= load_op_i;
         addr_q <= load_addr_i;
         id_q   <= load_id_i;
      end
   end

   assign cmd_valid_o = valid_q;
   assign cmd_op_o    = op_q;
   assign cmd_addr_o  = addr_q;
   assign cmd_id_o    = id_q;

   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_valid_o && !cmd_ready_i)
         |=> cmd_valid_o && $stable(cmd_op_o) && $stable(cmd_addr_o) && $stable(cmd_id_o))
      else $error("command changed under back-pressure");

   // the FSM never offers a command the register cannot take
   a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
      load_i |-> free_o)
      else $error("command offered while register busy");

endmodule

// ==== design/bank_fsm.sv ====
module bank_fsm
   import bank_cmd_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             head_valid_i,
   input  logic [ROW_W-1:0] head_row_i,
   input  logic [COL_W-1:0] head_col_i,
   input  logic             head_write_i,
   input  logic [ID_W-1:0]  head_id_i,
   input  logic             head_miss_i,
   input  logic             act_ok_i,
   input  logic             cas_ok_i,
   input  logic             pre_ok_i,
   input  logic             out_free_i,
   input  logic             fire_i,
   output logic             pop_o,
   output logic             issue_o,
   output bank_op_e         issue_op_o,
   output logic [ROW_W-1:0] issue_addr_o,
   output logic [ID_W-1:0]  issue_id_o,
   output logic             idle_o
);

   bank_state_e state_q;
   bank_state_e state_d;
   logic        pending_q;     // issued, waiting for the mux handshake
   logic        first_cas_q;   // next cas is the first after an ACT
   logic        can_issue;
   logic        go_act;
   logic        go_pre;
   logic        go_cas;

   // one command in flight at a time so the timers are always current
   assign can_issue = head_valid_i && out_free_i && !pending_q;

   always_comb
   begin
      go_act  = 1'b0;
      go_pre  = 1'b0;
      go_cas  = 1'b0;
      state_d = state_q;
      case (state_q)
         BANK_PRECHARGED:
         begin
            if (can_issue && act_ok_i)
            begin
               go_act  = 1'b1;
               state_d = BANK_ACTIVE;
            end
         end
         BANK_ACTIVE:
         begin
            // the head that caused the ACT is on the open row already
            if (head_miss_i && !first_cas_q)
            begin
               if (can_issue && pre_ok_i)
               begin
                  go_pre  = 1'b1;
                  state_d = BANK_PRECHARGED;
               end
            end
            else if (can_issue && cas_ok_i)
               go_cas = 1'b1;
         end
         default: state_d = BANK_PRECHARGED;
      endcase
   end

   assign issue_o = go_act | go_pre | go_cas;
   assign pop_o   = go_cas;   // head leaves as its cas is loaded

   always_comb
   begin
      issue_op_o   = OP_PRE;
      issue_addr_o = '0;
      issue_id_o   = '0;
      if (go_act)
      begin
         issue_op_o   = OP_ACT;
         issue_addr_o = head_row_i;
      end
      else if (go_cas)
      begin
         issue_op_o   = head_write_i ? OP_WR : OP_RD;
         issue_addr_o = {{(ROW_W - COL_W){1'b0}}, head_col_i};
         issue_id_o   = head_id_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= BANK_PRECHARGED;
         pending_q   <= 1'b0;
         first_cas_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (issue_o)
            pending_q <= 1'b1;
         else if (fire_i)
            pending_q <= 1'b0;
         if (go_act)
            first_cas_q <= 1'b1;
         else if (go_cas)
            first_cas_q <= 1'b0;
      end
   end

   assign idle_o = !head_valid_i && !pending_q;

   // cas only into an open row and after tRCD
   a_cas_after_rcd: assert property (@(posedge clk) disable iff (!rst_n)
      (issue_o && ((issue_op_o == OP_RD) || (issue_op_o == OP_WR)))
         |-> cas_ok_i && (state_q == BANK_ACTIVE))
      else $error("CAS issued before the row was ready");

endmodule

// ==== design/bank_timers.sv ====
module bank_timers
   import bank_cmd_pkg::*;
   import dram_timing_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     fire_i,
   input  bank_op_e fire_op_i,
   output logic     act_ok_o,
   output logic     cas_ok_o,
   output logic     pre_ok_o
);

   logic [TIMER_W-1:0] act2cas_q;
   logic [TIMER_W-1:0] act2pre_q;
   logic [TIMER_W-1:0] pre2act_q;
   logic [TIMER_W-1:0] cas2pre_q;
   logic [TIMER_W-1:0] cas_val;
   logic [TIMER_W-1:0] cas_load_val;
   logic               act_fire;
   logic               pre_fire;
   logic               cas_fire;

   function automatic logic [TIMER_W-1:0] step_cnt(
      input logic [TIMER_W-1:0] cnt,
      input logic               load,
      input logic [TIMER_W-1:0] load_val
   );
      logic [TIMER_W-1:0] nxt;
      nxt = cnt;
      if (load)
         nxt = load_val;
      else if (cnt != '0)
         nxt = cnt - 1'b1;
      return nxt;
   endfunction

   assign act_fire = fire_i && (fire_op_i == OP_ACT);
   assign pre_fire = fire_i && (fire_op_i == OP_PRE);
   assign cas_fire = fire_i && ((fire_op_i == OP_RD) || (fire_op_i == OP_WR));

   assign cas_val = (fire_op_i == OP_WR) ? TIMER_W'(T_WR2PRE - 1) : TIMER_W'(T_RD2PRE - 1);

   // back to back cas, keep the longer recovery of the two
   assign cas_load_val = (cas_val > cas2pre_q) ? cas_val : cas2pre_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         act2cas_q <= '0;
         act2pre_q <= '0;
         pre2act_q <= '0;
         cas2pre_q <= '0;
      end
      else
      begin
         act2cas_q <= step_cnt(act2cas_q, act_fire, TIMER_W'(T_RCD - 1));
         act2pre_q <= step_cnt(act2pre_q, act_fire, TIMER_W'(T_RAS - 1));
         pre2act_q <= step_cnt(pre2act_q, pre_fire, TIMER_W'(T_RP - 1));
         cas2pre_q <= step_cnt(cas2pre_q, cas_fire, cas_load_val);
      end
   end

   assign act_ok_o = (pre2act_q == '0);
   assign cas_ok_o = (act2cas_q == '0);
   assign pre_ok_o = (act2pre_q == '0) && (cas2pre_q == '0);

   // a row is opened and closed only once the previous window has run out
   a_act_reload: assert property (@(posedge clk) disable iff (!rst_n)
      act_fire |-> (act2cas_q == '0) && (act2pre_q == '0) && (pre2act_q == '0))
      else $error("ACT fired inside a running window");

   a_pre_reload: assert property (@(posedge clk) disable iff (!rst_n)
      pre_fire |-> (pre2act_q == '0) && (act2pre_q == '0) && (cas2pre_q == '0))
      else $error("PRE fired inside a running window");

endmodule

// ==== design/bank_req_queue.sv ====
module bank_req_queue
   import bank_cmd_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req_valid_i,
   input  logic [ROW_W-1:0] req_row_i,
   input  logic [COL_W-1:0] req_col_i,
   input  logic             req_write_i,
   input  logic [ID_W-1:0]  req_id_i,
   input  logic             pop_i,
   output logic             req_ready_o,
   output logic             head_valid_o,
   output logic [ROW_W-1:0] head_row_o,
   output logic [COL_W-1:0] head_col_o,
   output logic             head_write_o,
   output logic [ID_W-1:0]  head_id_o,
   output logic             head_miss_o
);

   logic [ROW_W-1:0]  row_mem   [QUEUE_DEPTH];
   logic [COL_W-1:0]  col_mem   [QUEUE_DEPTH];
   logic              write_mem [QUEUE_DEPTH];
   logic [ID_W-1:0]   id_mem    [QUEUE_DEPTH];
   logic              miss_mem  [QUEUE_DEPTH];
   logic [QPTR_W-1:0] wr_ptr_q;
   logic [QPTR_W-1:0] rd_ptr_q;
   logic [QPTR_W:0]   count_q;
   logic [ROW_W-1:0]  last_row_q;     // row of the newest accepted request
   logic              last_row_vld_q;
   logic              push;
   logic              pop;
   logic              req_miss;

   assign req_ready_o  = (count_q != QUEUE_DEPTH[QPTR_W:0]);
   assign head_valid_o = (count_q != '0);

   assign push = req_valid_i & req_ready_o;
   assign pop  = pop_i & head_valid_o;

   // a miss is a change of row against the request accepted before it
   assign req_miss = last_row_vld_q && (last_row_q != req_row_i);

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         row_mem[wr_ptr_q]   <= req_row_i;
         col_mem[wr_ptr_q]   <= req_col_i;
         write_mem[wr_ptr_q] <= req_write_i;
         id_mem[wr_ptr_q]    <= req_id_i;
         miss_mem[wr_ptr_q]  <= req_miss;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q       <= '0;
         rd_ptr_q       <= '0;
         count_q        <= '0;
         last_row_q     <= '0;
         last_row_vld_q <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q       <= wr_ptr_q + 1'b1;   // depth is a power of two
            last_row_q     <= req_row_i;
            last_row_vld_q <= 1'b1;
         end
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign head_row_o   = row_mem[rd_ptr_q];
   assign head_col_o   = col_mem[rd_ptr_q];
   assign head_write_o = write_mem[rd_ptr_q];
   assign head_id_o    = id_mem[rd_ptr_q];
   assign head_miss_o  = miss_mem[rd_ptr_q];

   // the FSM only consumes a head it has seen
   a_pop_with_head: assert property (@(posedge clk) disable iff (!rst_n)
      pop_i |-> head_valid_o)
      else $error("queue popped while empty");

endmodule

// ==== design/dram_timing_pkg.sv ====
package dram_timing_pkg;

   // spacings in whole controller cycles
   localparam int unsigned T_RCD    = 3;   // act to cas
   localparam int unsigned T_RAS    = 8;   // act to pre
   localparam int unsigned T_RP     = 3;   // pre to act

   // write recovery and read to precharge
   localparam int unsigned T_WR2PRE = 6;
   localparam int unsigned T_RD2PRE = 4;

   // wide enough for the largest spacing above
   localparam int unsigned TIMER_W  = 4;

endpackage

// ==== design/bank_cmd_pkg.sv ====
package bank_cmd_pkg;

   // request geometry for the single bank
   localparam int unsigned ROW_W = 16;
   localparam int unsigned COL_W = 11;
   localparam int unsigned ID_W  = 6;   // requester tag

   localparam int unsigned QUEUE_DEPTH = 8;
   localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);

   // commands handed to the command mux
   typedef enum logic [1:0]
   {
      OP_ACT = 2'b00,
      OP_PRE = 2'b01,
      OP_RD  = 2'b10,
      OP_WR  = 2'b11
   } bank_op_e;

   // open-page bank states
   typedef enum logic
   {
      BANK_PRECHARGED = 1'b0,
      BANK_ACTIVE     = 1'b1
   } bank_state_e;

endpackage
